// ==== rtl/lcd_pkg.sv ====
// lcd_pkg: stream entry type, coordinate and pixel count types, register map, panel commands
`default_nettype none

package lcd_pkg;

    // one word on the panel bus
    typedef struct packed {
        logic        rs;    // 0 command, 1 data
        logic [15:0] data;
    } lcd_entry_t;

    typedef logic [9:0]  coord_t;   // screen coordinate
    typedef logic [19:0] pix_cnt_t; // pixel count

    // apb register offsets
    localparam logic [7:0] REG_CTRL   = 8'h00; // bit 0 start
    localparam logic [7:0] REG_STATUS = 8'h04; // bit 0 busy, bit 1 bad_rect
    localparam logic [7:0] REG_XRANGE = 8'h08; // x0 9:0, x1 25:16
    localparam logic [7:0] REG_YRANGE = 8'h0C; // y0 9:0, y1 25:16
    localparam logic [7:0] REG_COLOR  = 8'h10;
    localparam logic [7:0] REG_PIXELS = 8'h14; // pixels of last frame

    // panel command codes
    localparam logic [15:0] CMD_CASET = 16'h002A; // column address set
    localparam logic [15:0] CMD_PASET = 16'h002B; // page (row) address set
    localparam logic [15:0] CMD_RAMWR = 16'h002C; // memory write

endpackage

`default_nettype wire

// ==== rtl/lcd_stream_if.sv ====
// lcd_stream_if: valid/ready stream of panel entries with src and dst modports
`default_nettype none

interface lcd_stream_if;

    logic                valid;
    logic                ready;
    lcd_pkg::lcd_entry_t entry;
    logic                last;  // final pixel of a frame

    modport src (
        output valid,
        output entry,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  entry,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== rtl/lcd_apb_regs.sv ====
// lcd_apb_regs: apb slave with rectangle, color, start, status and pixel count registers
`default_nettype none

module lcd_apb_regs (
    input  wire                pclk,
    input  wire                rst_n,
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire                pwrite_i,
    input  wire [7:0]          paddr_i,
    input  wire [31:0]         pwdata_i,
    input  wire                frame_done_i,
    input  wire lcd_pkg::pix_cnt_t pix_sent_i,
    output logic [31:0]        prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               start_o,
    output lcd_pkg::coord_t    x0_o,
    output lcd_pkg::coord_t    x1_o,
    output lcd_pkg::coord_t    y0_o,
    output lcd_pkg::coord_t    y1_o,
    output logic [15:0]        color_o
);

    logic              access;
    logic              wr_en;
    logic              addr_ok;
    logic              wr_ro;      // write to a read-only register
    logic              start_req;
    logic              rect_ok;
    logic              busy;
    logic              bad_rect;
    lcd_pkg::pix_cnt_t pixels;

    assign access    = psel_i & penable_i;
    assign wr_en     = access & pwrite_i;
    assign rect_ok   = (x0_o <= x1_o) && (y0_o <= y1_o);
    assign start_req = wr_en && (paddr_i == lcd_pkg::REG_CTRL) && pwdata_i[0];
    assign wr_ro     = pwrite_i && (paddr_i == lcd_pkg::REG_STATUS ||
                                    paddr_i == lcd_pkg::REG_PIXELS);

    assign pready_o  = 1'b1; // no wait states
    assign pslverr_o = access & (~addr_ok | wr_ro | (start_req & busy));

    always_comb begin
        addr_ok  = 1'b1;
        prdata_o = 32'h0;
        case (paddr_i)
            lcd_pkg::REG_CTRL:   prdata_o = 32'h0; // write only
            lcd_pkg::REG_STATUS: prdata_o = {30'h0, bad_rect, busy};
            lcd_pkg::REG_XRANGE: prdata_o = {6'h0, x1_o, 6'h0, x0_o};
            lcd_pkg::REG_YRANGE: prdata_o = {6'h0, y1_o, 6'h0, y0_o};
            lcd_pkg::REG_COLOR:  prdata_o = {16'h0, color_o};
            lcd_pkg::REG_PIXELS: prdata_o = {12'h0, pixels};
            default:             addr_ok  = 1'b0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            x0_o     <= '0;
            x1_o     <= '0;
            y0_o     <= '0;
            y1_o     <= '0;
            color_o  <= '0;
            busy     <= 1'b0;
            bad_rect <= 1'b0;
            start_o  <= 1'b0;
            pixels   <= '0;
        end else begin
            start_o <= 1'b0;

            // rectangle and color are frozen while a frame runs
            if (wr_en && !busy) begin
                case (paddr_i)
                    lcd_pkg::REG_XRANGE: begin
                        x0_o <= pwdata_i[9:0];
                        x1_o <= pwdata_i[25:16];
                    end
                    lcd_pkg::REG_YRANGE: begin
                        y0_o <= pwdata_i[9:0];
                        y1_o <= pwdata_i[25:16];
                    end
                    lcd_pkg::REG_COLOR: color_o <= pwdata_i[15:0];
                    default: ;
                endcase
            end

            if (start_req && !busy) begin
                if (rect_ok) begin
                    start_o  <= 1'b1;
                    busy     <= 1'b1;
                    bad_rect <= 1'b0;
                end else begin
                    bad_rect <= 1'b1; // inverted rectangle, nothing drawn
                end
            end

            if (frame_done_i) begin
                busy   <= 1'b0;
                pixels <= pix_sent_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_cmd_gen.sv ====
// lcd_cmd_gen: turns a draw request into the caset/paset/ramwr command and pixel stream
`default_nettype none

module lcd_cmd_gen (
    input  wire                  pclk,
    input  wire                  rst_n,
    input  wire                  start_i,
    input  wire lcd_pkg::coord_t x0_i,
    input  wire lcd_pkg::coord_t x1_i,
    input  wire lcd_pkg::coord_t y0_i,
    input  wire lcd_pkg::coord_t y1_i,
    input  wire [15:0]           color_i,
    lcd_stream_if.src            out_s
);

    typedef enum logic [3:0] {
        IDLE,
        CASET,
        X0,
        X1,
        PASET,
        Y0,
        Y1,
        RAMWR,
        PIXELS
    } gen_state_t;

    gen_state_t        state;
    lcd_pkg::pix_cnt_t pix_left;  // pixels still to send, minus one
    logic [10:0]       width;
    logic [10:0]       height;
    logic [21:0]       area_m1;
    logic              xfer;

    // coordinates stay stable while busy, so they are read straight from the inputs
    assign width   = {1'b0, x1_i} - {1'b0, x0_i} + 11'd1;
    assign height  = {1'b0, y1_i} - {1'b0, y0_i} + 11'd1;
    assign area_m1 = width * height - 22'd1;

    assign xfer = out_s.valid & out_s.ready;

    assign out_s.valid = (state != IDLE);
    assign out_s.last  = (state == PIXELS) && (pix_left == '0);

    always_comb begin
        out_s.entry.rs   = 1'b1;
        out_s.entry.data = 16'h0;
        case (state)
            CASET: begin
                out_s.entry.rs   = 1'b0;
                out_s.entry.data = lcd_pkg::CMD_CASET;
            end
            X0:    out_s.entry.data = {6'h0, x0_i};
            X1:    out_s.entry.data = {6'h0, x1_i};
            PASET: begin
                out_s.entry.rs   = 1'b0;
                out_s.entry.data = lcd_pkg::CMD_PASET;
            end
            Y0:    out_s.entry.data = {6'h0, y0_i};
            Y1:    out_s.entry.data = {6'h0, y1_i};
            RAMWR: begin
                out_s.entry.rs   = 1'b0;
                out_s.entry.data = lcd_pkg::CMD_RAMWR;
            end
            PIXELS: out_s.entry.data = color_i;
            default: ;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state    <= IDLE;
            pix_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state    <= CASET;
                        pix_left <= area_m1[19:0];
                    end
                end
                CASET:  if (xfer) state <= X0;
                X0:     if (xfer) state <= X1;
                X1:     if (xfer) state <= PASET;
                PASET:  if (xfer) state <= Y0;
                Y0:     if (xfer) state <= Y1;
                Y1:     if (xfer) state <= RAMWR;
                RAMWR:  if (xfer) state <= PIXELS;
                PIXELS: begin
                    if (xfer) begin
                        if (pix_left == '0) begin
                            state <= IDLE; // frame fully handed off
                        end else begin
                            pix_left <= pix_left - 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_cmd_fifo.sv ====
// lcd_cmd_fifo: synchronous circular-buffer fifo between stream producer and consumer
`default_nettype none

module lcd_cmd_fifo #(
    parameter int DEPTH = 8  // power of two
) (
    input  wire       pclk,
    input  wire       rst_n,
    lcd_stream_if.dst in_s,
    lcd_stream_if.src out_s
);

    localparam int AW = $clog2(DEPTH);

    lcd_pkg::lcd_entry_t mem_entry [DEPTH];
    logic                mem_last  [DEPTH];

    logic [AW:0] wr_ptr;  // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign push = in_s.valid & in_s.ready;
    assign pop  = out_s.valid & out_s.ready;

    assign in_s.ready  = ~full;
    assign out_s.valid = ~empty;
    assign out_s.entry = mem_entry[rd_ptr[AW-1:0]];
    assign out_s.last  = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge pclk) begin
        if (push) begin
            mem_entry[wr_ptr[AW-1:0]] <= in_s.entry;
            mem_last[wr_ptr[AW-1:0]]  <= in_s.last;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_bus_writer.sv ====
// lcd_bus_writer: drives 8080-style panel write cycles from stream entries
`default_nettype none

module lcd_bus_writer #(
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input  wire               pclk,
    input  wire               rst_n,
    lcd_stream_if.dst         in_s,
    output logic              lcd_cs_n_o,
    output logic              lcd_rs_o,
    output logic              lcd_wr_n_o,
    output logic [15:0]       lcd_data_o,
    output logic              frame_done_o,
    output lcd_pkg::pix_cnt_t pix_sent_o
);

    localparam int PERIOD = WR_LOW_CYCLES + WR_HIGH_CYCLES;
    localparam int PW     = $clog2(PERIOD);

    logic          active;    // an entry is on the bus
    logic [PW-1:0] phase;     // position inside the strobe period
    logic          cur_last;
    logic          in_pixels; // past ramwr, data words are pixels
    logic          end_high;
    logic          accept;

    assign end_high = active && (phase == PW'(PERIOD - 1));
    // hold off the next frame until cs has been released
    assign in_s.ready = !active || (end_high && !cur_last);
    assign accept     = in_s.valid & in_s.ready;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            active       <= 1'b0;
            phase        <= '0;
            cur_last     <= 1'b0;
            in_pixels    <= 1'b0;
            lcd_cs_n_o   <= 1'b1;
            lcd_wr_n_o   <= 1'b1;
            lcd_rs_o     <= 1'b0;
            lcd_data_o   <= '0;
            frame_done_o <= 1'b0;
            pix_sent_o   <= '0;
        end else begin
            frame_done_o <= 1'b0;

            if (active) begin
                phase <= phase + 1'b1;
                if (phase == PW'(WR_LOW_CYCLES - 1)) begin
                    lcd_wr_n_o <= 1'b1; // panel latches here
                end
            end

            if (end_high && !accept) begin
                active <= 1'b0;
                if (cur_last) begin
                    lcd_cs_n_o   <= 1'b1;
                    frame_done_o <= 1'b1;
                end
            end

            if (accept) begin
                active     <= 1'b1;
                phase      <= '0;
                cur_last   <= in_s.last;
                lcd_cs_n_o <= 1'b0;
                lcd_wr_n_o <= 1'b0;
                lcd_rs_o   <= in_s.entry.rs;
                lcd_data_o <= in_s.entry.data;
                if (!in_s.entry.rs) begin
                    // a ramwr opens the pixel run and restarts the count
                    in_pixels <= (in_s.entry.data == lcd_pkg::CMD_RAMWR);
                    if (in_s.entry.data == lcd_pkg::CMD_RAMWR) begin
                        pix_sent_o <= '0;
                    end
                end else if (in_pixels) begin
                    pix_sent_o <= pix_sent_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_draw_top.sv ====
// lcd_draw_top: apb registers, command generator, fifo and panel bus writer
`default_nettype none

module lcd_draw_top #(
    parameter int FIFO_DEPTH     = 8,
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input  wire         pclk,
    input  wire         rst_n,
    input  wire         psel_i,
    input  wire         penable_i,
    input  wire         pwrite_i,
    input  wire [7:0]   paddr_i,
    input  wire [31:0]  pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output logic        lcd_cs_n_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_n_o,
    output logic [15:0] lcd_data_o
);

    logic              start;
    lcd_pkg::coord_t   x0;
    lcd_pkg::coord_t   x1;
    lcd_pkg::coord_t   y0;
    lcd_pkg::coord_t   y1;
    logic [15:0]       color;
    logic              frame_done;
    lcd_pkg::pix_cnt_t pix_sent;

    lcd_stream_if gen_s ();  // generator to fifo
    lcd_stream_if wr_s ();   // fifo to writer

    lcd_apb_regs lcd_apb_regs_inst (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .frame_done_i (frame_done),
        .pix_sent_i   (pix_sent),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .start_o      (start),
        .x0_o         (x0),
        .x1_o         (x1),
        .y0_o         (y0),
        .y1_o         (y1),
        .color_o      (color)
    );

    lcd_cmd_gen lcd_cmd_gen_inst (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .start_i (start),
        .x0_i    (x0),
        .x1_i    (x1),
        .y0_i    (y0),
        .y1_i    (y1),
        .color_i (color),
        .out_s   (gen_s.src)
    );

    lcd_cmd_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) lcd_cmd_fifo_inst (
        .pclk  (pclk),
        .rst_n (rst_n),
        .in_s  (gen_s.dst),
        .out_s (wr_s.src)
    );

    lcd_bus_writer #(
        .WR_LOW_CYCLES  (WR_LOW_CYCLES),
        .WR_HIGH_CYCLES (WR_HIGH_CYCLES)
    ) lcd_bus_writer_inst (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .in_s         (wr_s.dst),
        .lcd_cs_n_o   (lcd_cs_n_o),
        .lcd_rs_o     (lcd_rs_o),
        .lcd_wr_n_o   (lcd_wr_n_o),
        .lcd_data_o   (lcd_data_o),
        .frame_done_o (frame_done),
        .pix_sent_o   (pix_sent)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_lcd_draw.sv ====
// tb_lcd_draw: clock, reset, apb tasks, panel bus monitor, reference model and checks
`default_nettype none

module tb_lcd_draw;

    localparam int NUM_FRAMES     = 30;
    localparam int TIMEOUT_CYCLES = 40 * (7 + 256) * 4 + 5000; // frames x entries x period

    logic        pclk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        lcd_cs_n;
    logic        lcd_rs;
    logic        lcd_wr_n;
    logic [15:0] lcd_data;

    integer              seed;
    int                  err_cnt;
    int                  check_cnt;
    int                  cycle_cnt;
    int                  cs_rise_cnt;
    int                  cs_rise_at;  // words captured when cs went high
    lcd_pkg::lcd_entry_t cap_q[$];    // words latched by the panel
    lcd_pkg::lcd_entry_t exp_q[$];    // model sequence

    lcd_draw_top lcd_draw_top_inst (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .lcd_cs_n_o (lcd_cs_n),
        .lcd_rs_o   (lcd_rs),
        .lcd_wr_n_o (lcd_wr_n),
        .lcd_data_o (lcd_data)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge pclk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // the panel latches rs and data on the rising edge of wr_n
    always @(posedge lcd_wr_n) begin
        if (rst_n === 1'b1) begin
            cap_q.push_back(make_entry(lcd_rs, lcd_data));
            check_bit("lcd_cs_n_o at strobe", lcd_cs_n, 1'b0);
        end
    end

    always @(posedge lcd_cs_n) begin
        if (rst_n === 1'b1) begin
            cs_rise_cnt = cs_rise_cnt + 1;
            cs_rise_at  = cap_q.size();
        end
    end

    function automatic lcd_pkg::lcd_entry_t make_entry(input logic rs, input logic [15:0] data);
        lcd_pkg::lcd_entry_t e;
        e.rs   = rs;
        e.data = data;
        return e;
    endfunction

    task automatic check_entry(input string name, input lcd_pkg::lcd_entry_t got,
                               input lcd_pkg::lcd_entry_t exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // setup cycle, access cycle, then back to idle
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge pclk);
        penable = 1'b1;
        #5 err  = pslverr; // mid low phase, well before the completing edge
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge pclk);
        penable = 1'b1;
        #5;
        data    = prdata;
        err     = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic random_span(output lcd_pkg::coord_t lo, output lcd_pkg::coord_t hi);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        lo = (a[3:0] < b[3:0]) ? {6'h0, a[3:0]} : {6'h0, b[3:0]};
        hi = (a[3:0] < b[3:0]) ? {6'h0, b[3:0]} : {6'h0, a[3:0]};
    endtask

    // commands, coordinates, then one color word per pixel
    task automatic build_expected(input lcd_pkg::coord_t x0, input lcd_pkg::coord_t x1,
                                  input lcd_pkg::coord_t y0, input lcd_pkg::coord_t y1,
                                  input logic [15:0] color, input int area);
        exp_q.delete();
        exp_q.push_back(make_entry(1'b0, lcd_pkg::CMD_CASET));
        exp_q.push_back(make_entry(1'b1, {6'h0, x0}));
        exp_q.push_back(make_entry(1'b1, {6'h0, x1}));
        exp_q.push_back(make_entry(1'b0, lcd_pkg::CMD_PASET));
        exp_q.push_back(make_entry(1'b1, {6'h0, y0}));
        exp_q.push_back(make_entry(1'b1, {6'h0, y1}));
        exp_q.push_back(make_entry(1'b0, lcd_pkg::CMD_RAMWR));
        for (int i = 0; i < area; i++) begin
            exp_q.push_back(make_entry(1'b1, color));
        end
    endtask

    task automatic run_frame(input lcd_pkg::coord_t x0, input lcd_pkg::coord_t x1,
                             input lcd_pkg::coord_t y0, input lcd_pkg::coord_t y1,
                             input logic [15:0] color, input logic poke_busy);
        logic [31:0] rdata;
        logic        err;
        int          area;
        int          rises_before;
        int          n;
        area = (int'(x1) - int'(x0) + 1) * (int'(y1) - int'(y0) + 1);
        build_expected(x0, x1, y0, y1, color, area);
        apb_write(lcd_pkg::REG_XRANGE, {6'h0, x1, 6'h0, x0}, err);
        apb_write(lcd_pkg::REG_YRANGE, {6'h0, y1, 6'h0, y0}, err);
        apb_write(lcd_pkg::REG_COLOR, {16'h0, color}, err);
        cap_q.delete();
        rises_before = cs_rise_cnt;
        apb_write(lcd_pkg::REG_CTRL, 32'h1, err);
        check_bit("pslverr_o on start", err, 1'b0);
        apb_read(lcd_pkg::REG_STATUS, rdata, err);
        check_word("REG_STATUS after start", rdata, 32'h1); // busy, bad_rect cleared
        if (poke_busy) begin
            apb_write(lcd_pkg::REG_CTRL, 32'h1, err);
            check_bit("pslverr_o on start while busy", err, 1'b1);
        end
        rdata = 32'h1;
        while (rdata[0]) begin
            apb_read(lcd_pkg::REG_STATUS, rdata, err);
        end
        check_word("captured word count", cap_q.size(), exp_q.size());
        n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_entry($sformatf("panel word %0d", i), cap_q[i], exp_q[i]);
        end
        check_word("cs release count", cs_rise_cnt, rises_before + 1);
        check_word("words before cs release", cs_rise_at, exp_q.size());
        check_bit("lcd_cs_n_o after frame", lcd_cs_n, 1'b1);
        apb_read(lcd_pkg::REG_PIXELS, rdata, err);
        check_word("REG_PIXELS", rdata, area);
        cap_q.delete();
    endtask

    // inverted rectangle, nothing may reach the panel
    task automatic bad_start(input logic [31:0] xrange, input logic [31:0] yrange);
        logic [31:0] rdata;
        logic        err;
        apb_write(lcd_pkg::REG_XRANGE, xrange, err);
        apb_write(lcd_pkg::REG_YRANGE, yrange, err);
        cap_q.delete();
        apb_write(lcd_pkg::REG_CTRL, 32'h1, err);
        check_bit("pslverr_o on bad start", err, 1'b0);
        apb_read(lcd_pkg::REG_STATUS, rdata, err);
        check_word("REG_STATUS after bad start", rdata, 32'h2);
        repeat (50) @(negedge pclk);
        check_word("strobes after bad start", cap_q.size(), 32'h0);
        check_bit("lcd_cs_n_o after bad start", lcd_cs_n, 1'b1);
    endtask

    initial begin : stimulus
        logic [31:0]     rdata;
        logic [31:0]     wdata;
        logic [31:0]     r;
        logic            err;
        lcd_pkg::coord_t x0;
        lcd_pkg::coord_t x1;
        lcd_pkg::coord_t y0;
        lcd_pkg::coord_t y1;

        seed        = 32'hb6647bef;
        err_cnt     = 0;
        check_cnt   = 0;
        cs_rise_cnt = 0;
        cs_rise_at  = 0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 8'h0;
        pwdata      = 32'h0;
        repeat (16) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        // reset values on the pins
        check_bit("lcd_cs_n_o after reset", lcd_cs_n, 1'b1);
        check_bit("lcd_wr_n_o after reset", lcd_wr_n, 1'b1);
        check_entry("lcd rs/data after reset", make_entry(lcd_rs, lcd_data),
                    make_entry(1'b0, 16'h0));
        check_bit("pslverr_o after reset", pslverr, 1'b0);
        check_bit("pready_o after reset", pready, 1'b1);
        apb_read(lcd_pkg::REG_STATUS, rdata, err);
        check_word("REG_STATUS after reset", rdata, 32'h0);

        // register readback with field masking
        wdata = 32'hffff_ffff;
        apb_write(lcd_pkg::REG_XRANGE, wdata, err);
        check_bit("pslverr_o on REG_XRANGE write", err, 1'b0);
        apb_read(lcd_pkg::REG_XRANGE, rdata, err);
        check_word("REG_XRANGE", rdata, {6'h0, wdata[25:16], 6'h0, wdata[9:0]});
        wdata = 32'ha5a5_5a5a;
        apb_write(lcd_pkg::REG_YRANGE, wdata, err);
        check_bit("pslverr_o on REG_YRANGE write", err, 1'b0);
        apb_read(lcd_pkg::REG_YRANGE, rdata, err);
        check_word("REG_YRANGE", rdata, {6'h0, wdata[25:16], 6'h0, wdata[9:0]});
        wdata = 32'h1234_beef;
        apb_write(lcd_pkg::REG_COLOR, wdata, err);
        check_bit("pslverr_o on REG_COLOR write", err, 1'b0);
        apb_read(lcd_pkg::REG_COLOR, rdata, err);
        check_word("REG_COLOR", rdata, {16'h0, wdata[15:0]});
        apb_read(lcd_pkg::REG_PIXELS, rdata, err);
        check_word("REG_PIXELS after reset", rdata, 32'h0);
        apb_write(8'h18, 32'h1, err);
        check_bit("pslverr_o on unmapped write", err, 1'b1);
        apb_read(8'h1c, rdata, err);
        check_bit("pslverr_o on unmapped read", err, 1'b1);
        apb_write(lcd_pkg::REG_STATUS, 32'h3, err);
        check_bit("pslverr_o on REG_STATUS write", err, 1'b1);
        apb_write(lcd_pkg::REG_PIXELS, 32'h5, err);
        check_bit("pslverr_o on REG_PIXELS write", err, 1'b1);

        // x0 > x1 now and y0 > y1 midway, each followed by a frame that clears bad_rect
        bad_start({6'h0, 10'd3, 6'h0, 10'd9}, {6'h0, 10'd4, 6'h0, 10'd1});

        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f == NUM_FRAMES / 2) begin
                bad_start({6'h0, 10'd7, 6'h0, 10'd2}, {6'h0, 10'd0, 6'h0, 10'd12});
            end
            random_span(x0, x1);
            random_span(y0, y1);
            r = $random(seed);
            run_frame(x0, x1, y0, y1, r[15:0], (f % 10) == 3); // some frames get a second start
        end

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/lcd_pkg.sv
rtl/lcd_stream_if.sv
rtl/lcd_apb_regs.sv
rtl/lcd_cmd_gen.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_bus_writer.sv
rtl/lcd_draw_top.sv
testbench/tb_lcd_draw.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compiles and runs the lcd drawing engine testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_lcd_draw

verilator --binary --timing -f sim.f --top-module "$TOP" -Mdir obj_dir -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

exit 0
